// File: flist.f
logic/rv_pkg.sv
logic/ramio_if.sv
logic/registers.sv
logic/core.sv
logic/ramio.sv
logic/soc_top.sv
sim/spi_flash_model.sv
sim/tb_soc.sv

// File: Makefile
# Verilator flow for the flash-boot rv32i system

VERILATOR ?= verilator
TOP       ?= tb_soc
RTL_TOP   ?= soc_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --timing -Wno-fatal
SIM_ARGS  ?=

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(filter logic/%,$(SRCS))

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

sim: $(BIN)
	-./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_soc.sv
/*
 * tb_soc: testbench for the flash-boot rv32i system.
 * Boots a hand-assembled program from the flash model and checks its io writes.
 */
module tb_soc;
  import rv_pkg::*;

  localparam int     clk_period      = 8;
  localparam int     reset_cycles    = 16;
  localparam int     io_count        = 26;
  localparam int     executed_instrs = 80;  // program plus loop passes, rounded up
  localparam int     flash_bits      = 32 + 8 * flash_transfer_bytes;
  localparam longint watchdog_cycles = 2 * (16 * flash_bits + startup_wait_cycles
                                            + 20 * executed_instrs) + reset_cycles;
  localparam int     quiet_cycles    = 200;
  localparam int     led_wait_cycles = 20;  // one instruction's budget

  logic  clk;
  logic  rst_n;
  logic  led;
  logic  flash_clk;
  logic  flash_miso;
  logic  flash_mosi;
  logic  flash_cs;
  logic  io_valid;
  logic  cmd_ok;
  word_t io_data;
  byte_t flash_image [flash_transfer_bytes];
  word_t program_words [$];

  // values the program writes to io_addr, in order
  word_t expected_io [io_count] = '{
    32'h0000_005d, 32'hffff_ff95, 32'hffff_ff9d, 32'h0000_00f0, 32'h0000_0640,
    32'hffff_fffc, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 32'h1234_5000,
    32'h0000_105c, 32'h8001_8000, 32'hffff_ff80, 32'h0000_0080, 32'hffff_8001,
    32'h0000_8001, 32'h0000_0005, 32'h0000_0004, 32'h0000_0003, 32'h0000_0002,
    32'h0000_0001, 32'hffff_fff9, 32'h0000_0200, 32'h0000_00dc, 32'h0000_00e8,
    32'h0000_0000
  };

  soc_top uut (
    .clk,
    .rst_n,
    .led,
    .flash_clk,
    .flash_miso,
    .flash_mosi,
    .flash_cs,
    .io_valid,
    .io_data
  );

  spi_flash_model flash (
    .flash_clk,
    .flash_cs,
    .flash_mosi,
    .flash_miso,
    .image (flash_image),
    .cmd_ok
  );

  function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, reg_addr_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // sw src, -16(x31) with x31 = 0x1000 hits io_addr
  function automatic word_t store_to_io(reg_addr_t src);
    return s_type(12'hff0, src, 5'd31, 3'b010);
  endfunction

  task automatic assemble_program();
    program_words.push_back(u_type(20'h00001, 5'd31, op_lui));
    program_words.push_back(i_type(12'd100, 5'd0, 3'b000, 5'd1, op_alu_imm));
    program_words.push_back(i_type(12'hff9, 5'd0, 3'b000, 5'd2, op_alu_imm)); // x2 = -7
    program_words.push_back(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, op_alu));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(r_type(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd3, op_alu));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(r_type(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd3, op_alu));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'h0f0, 5'd2, 3'b111, 5'd3, op_alu_imm));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'd4, 5'd1, 3'b001, 5'd3, op_alu_imm));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'h401, 5'd2, 3'b101, 5'd3, op_alu_imm)); // srai 1
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(r_type(7'b0100000, 5'd1, 5'd2, 3'b101, 5'd3, op_alu)); // shamt 4
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(r_type(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd3, op_alu));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(r_type(7'b0000000, 5'd1, 5'd2, 3'b011, 5'd3, op_alu));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(u_type(20'h12345, 5'd3, op_lui));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(u_type(20'h00001, 5'd3, op_auipc)); // at 0x5c
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'd512, 5'd0, 3'b000, 5'd5, op_alu_imm));
    program_words.push_back(s_type(12'd0, 5'd0, 5'd5, 3'b010));
    program_words.push_back(i_type(12'd128, 5'd0, 3'b000, 5'd6, op_alu_imm));
    program_words.push_back(s_type(12'd1, 5'd6, 5'd5, 3'b000));
    program_words.push_back(u_type(20'h00008, 5'd7, op_lui));
    program_words.push_back(i_type(12'd1, 5'd7, 3'b000, 5'd7, op_alu_imm));
    program_words.push_back(s_type(12'd2, 5'd7, 5'd5, 3'b001));
    program_words.push_back(i_type(12'd0, 5'd5, 3'b010, 5'd3, op_load));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'd1, 5'd5, 3'b000, 5'd3, op_load));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'd1, 5'd5, 3'b100, 5'd3, op_load));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'd2, 5'd5, 3'b001, 5'd3, op_load));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'd2, 5'd5, 3'b101, 5'd3, op_load));
    program_words.push_back(store_to_io(5'd3));
    program_words.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd8, op_alu_imm));
    program_words.push_back(store_to_io(5'd8)); // loop top
    program_words.push_back(i_type(12'hfff, 5'd8, 3'b000, 5'd8, op_alu_imm));
    program_words.push_back(b_type(13'h1ff8, 5'd0, 5'd8, 3'b001));
    program_words.push_back(b_type(13'd8, 5'd1, 5'd2, 3'b100)); // blt taken
    program_words.push_back(store_to_io(5'd1));
    program_words.push_back(b_type(13'd8, 5'd1, 5'd2, 3'b101)); // bge not taken
    program_words.push_back(store_to_io(5'd2));
    program_words.push_back(b_type(13'd8, 5'd1, 5'd2, 3'b110)); // bltu not taken
    program_words.push_back(store_to_io(5'd5));
    program_words.push_back(b_type(13'd8, 5'd1, 5'd2, 3'b111)); // bgeu taken
    program_words.push_back(store_to_io(5'd6));
    program_words.push_back(j_type(21'd8, 5'd12)); // at 0xd8
    program_words.push_back(store_to_io(5'd0));
    program_words.push_back(store_to_io(5'd12));
    program_words.push_back(i_type(12'd236, 5'd0, 3'b000, 5'd13, op_jalr)); // at 0xe4
    program_words.push_back(store_to_io(5'd0));
    program_words.push_back(store_to_io(5'd13));
    program_words.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd0, op_alu_imm));
    program_words.push_back(store_to_io(5'd0));
    program_words.push_back(32'h0000_0000); // undefined opcode
  endtask

  // little-endian bytes per word, zero padded
  task automatic build_image();
    word_t w;
    assemble_program();
    for (int i = 0; i < flash_transfer_bytes / 4; i++) begin
      w = (i < program_words.size()) ? program_words[i] : '0;
      for (int b = 0; b < 4; b++) begin
        flash_image[4*i + b] = w[8*b +: 8];
      end
    end
  endtask

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(word_t got, word_t expected, string what);
    if (got !== expected) begin
      $display("ERR @%0t: %s expected %h, got %h", $time, what, expected, got);
      abort_run();
    end
  endtask

  task automatic check_bit(logic got, logic expected, string what);
    if (got !== expected) begin
      $display("ERR @%0t: %s expected %b, got %b", $time, what, expected, got);
      abort_run();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog: the run timed out before all checks were done");
    abort_run();
  end

  initial begin
    rst_n = 1'b0;
    build_image();
    @(posedge clk);
    @(negedge clk);
    check_bit(flash_cs, 1'b1, "flash_cs during reset");
    check_bit(led, 1'b1, "led during reset");
    check_bit(io_valid, 1'b0, "io_valid during reset");
    repeat (reset_cycles - 1) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit(flash_cs, 1'b1, "flash_cs after reset");
    check_bit(led, 1'b1, "led after reset");
    check_bit(io_valid, 1'b0, "io_valid after reset");

    while (flash_cs) @(negedge clk);
    while (!flash_cs) @(negedge clk); // boot copy done
    check_bit(cmd_ok, 1'b1, "flash read command and address");

    for (int n = 0; n < io_count; n++) begin
      do begin
        @(negedge clk);
        if (!led) begin
          $display("core stopped on an illegal instruction before io value %0d", n);
          abort_run();
        end
      end while (!io_valid);
      check_word(io_data, expected_io[n], $sformatf("io value %0d", n));
    end

    // the undefined opcode is next in line
    for (int c = 0; c < led_wait_cycles && led; c++) begin
      @(negedge clk);
    end
    check_bit(led, 1'b0, "led after the undefined opcode");
    repeat (quiet_cycles) begin
      @(negedge clk);
      if (io_valid) begin
        $display("an io write came after the undefined opcode");
        abort_run();
      end
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: sim/spi_flash_model.sv
/*
 * spi_flash_model: behavioral SPI flash for the boot transfer.
 * Checks the read command and address, then shifts out the image msb first.
 */
module spi_flash_model (
  input  logic          flash_clk,
  input  logic          flash_cs,
  input  logic          flash_mosi,
  output logic          flash_miso,
  input  rv_pkg::byte_t image [rv_pkg::flash_transfer_bytes],
  output logic          cmd_ok
);
  import rv_pkg::*;

  localparam int image_bits = 8 * flash_transfer_bytes;

  logic [31:0] rx_word;  // command byte then 24-bit address
  int          rx_bits;
  int          tx_bit;   // next bit of the image stream

  initial begin
    flash_miso = 1'b0;
    cmd_ok     = 1'b0;
    rx_word    = '0;
    rx_bits    = 0;
    tx_bit     = 0;
  end

  // mosi is sampled on the rising flash clock
  always @(posedge flash_clk) begin
    if (!flash_cs && rx_bits < 32) begin
      rx_word = {rx_word[30:0], flash_mosi};
      rx_bits = rx_bits + 1;
      if (rx_bits == 32) begin
        if (rx_word == {flash_read_cmd, 24'h000000}) begin
          cmd_ok = 1'b1;
        end else begin
          $display("flash model: expected read command %h at address 0, received %h",
                   flash_read_cmd, rx_word);
        end
      end
    end
  end

  // miso moves after each falling flash clock once the header is in
  always @(negedge flash_clk) begin
    if (!flash_cs && rx_bits >= 32 && tx_bit < image_bits) begin
      flash_miso <= image[tx_bit / 8][7 - (tx_bit % 8)];
      tx_bit = tx_bit + 1;
    end
  end

endmodule

// File: logic/soc_top.sv
/*
 * soc_top: rv32i system that boots from SPI flash.
 * Joins the core, its register file and the RAM with the io word.
 */
module soc_top (
  input  logic          clk,
  input  logic          rst_n,
  output logic          led,
  output logic          flash_clk,
  input  logic          flash_miso,
  output logic          flash_mosi,
  output logic          flash_cs,
  output logic          io_valid,
  output rv_pkg::word_t io_data
);
  import rv_pkg::*;

  ramio_if mem_bus ();

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     rs1_data_out;
  word_t     rs2_data_out;
  word_t     rd_data_in;
  logic      rd_write_enable;

  core u_core (
    .clk,
    .rst_n,
    .led,
    .mem (mem_bus),
    .flash_clk,
    .flash_miso,
    .flash_mosi,
    .flash_cs,
    .rs1,
    .rs2,
    .rs1_data_out,
    .rs2_data_out,
    .rd,
    .rd_write_enable,
    .rd_data_in
  );

  registers u_registers (
    .clk,
    .rs1,
    .rs2,
    .rs1_data_out,
    .rs2_data_out,
    .rd,
    .rd_write_enable,
    .rd_data_in
  );

  ramio u_ramio (
    .clk,
    .rst_n,
    .mem (mem_bus),
    .io_valid,
    .io_data
  );

endmodule

// File: logic/ramio.sv
/*
 * ramio: byte-addressed RAM with byte, half and word access.
 * Tracks the request on the memory port, answers with busy and data_out_ready,
 * and maps a word write to io_addr onto a one-cycle io strobe.
 */
module ramio (
  input  logic          clk,
  input  logic          rst_n,
  ramio_if.mem          mem,
  output logic          io_valid,
  output rv_pkg::word_t io_data
);
  import rv_pkg::*;

  byte_t [3:0] ram [ram_words];

  logic                    served;    // current request already taken
  logic                    rd_valid;  // last taken request was a read
  word_t                   last_addr;
  read_type_t              last_rt;
  write_type_t             last_wt;
  logic                    same_req;
  logic                    take;
  logic                    io_hit;
  logic [ram_idx_bits-1:0] idx;
  logic [1:0]              ofs;
  logic [3:0]              lane_en;
  word_t                   lane_data;
  word_t                   word_rd;
  word_t                   shifted;
  word_t                   rd_ext;

  assign idx      = mem.address[ram_idx_bits+1:2]; // wraps inside the RAM
  assign ofs      = mem.address[1:0];
  assign same_req = served && mem.address == last_addr
                    && mem.read_type == last_rt && mem.write_type == last_wt;
  assign take     = mem.enable && !mem.busy && !same_req;
  assign io_hit   = mem.address == io_addr && mem.write_type == wt_word;

  assign mem.data_out_ready = rd_valid && mem.enable && same_req;

  always_comb begin
    case (mem.write_type)
      wt_byte: begin
        lane_en   = 4'b0001 << ofs;
        lane_data = {4{mem.data_in[7:0]}};
      end
      wt_half: begin
        lane_en   = 4'b0011 << {ofs[1], 1'b0};
        lane_data = {2{mem.data_in[15:0]}};
      end
      wt_word: begin
        lane_en   = 4'b1111;
        lane_data = mem.data_in;
      end
      default: begin
        lane_en   = 4'b0000;
        lane_data = mem.data_in;
      end
    endcase
  end

  assign word_rd = ram[idx];
  assign shifted = word_rd >> {ofs, 3'b000}; // addressed lane down to bit 0

  always_comb begin
    case (mem.read_type[1:0])
      2'd1: rd_ext = {{24{mem.read_type[2] & shifted[7]}}, shifted[7:0]};
      2'd2: rd_ext = {{16{mem.read_type[2] & shifted[15]}}, shifted[15:0]};
      default: rd_ext = shifted;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      served    <= 1'b0;
      rd_valid  <= 1'b0;
      last_addr <= '0;
      last_rt   <= rt_none;
      last_wt   <= wt_none;
      mem.busy  <= 1'b0;
      io_valid  <= 1'b0;
    end else begin
      mem.busy <= take && mem.write_type != wt_none; // one cycle after a write
      io_valid <= take && io_hit;
      if (!mem.enable) begin
        served <= 1'b0;
      end else if (take) begin
        served    <= 1'b1;
        rd_valid  <= mem.read_type != rt_none;
        last_addr <= mem.address;
        last_rt   <= mem.read_type;
        last_wt   <= mem.write_type;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && !io_hit) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) begin
          ram[idx][i] <= lane_data[8*i +: 8];
        end
      end
    end
    if (take && mem.read_type != rt_none) begin
      mem.data_out <= rd_ext;
    end
    if (take && io_hit) begin
      io_data <= mem.data_in;
    end
  end

endmodule

// File: logic/core.sv
/*
 * core: flash boot sequencer and multi-cycle rv32i FSM.
 * After a startup wait it copies the program image from SPI flash into RAM,
 * then fetches and executes from address 0 over the memory port.
 */
module core (
  input  logic              clk,
  input  logic              rst_n,
  output logic              led,
  ramio_if.core             mem,
  output logic              flash_clk,
  input  logic              flash_miso,
  output logic              flash_mosi,
  output logic              flash_cs,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  input  rv_pkg::word_t     rs1_data_out,
  input  rv_pkg::word_t     rs2_data_out,
  output rv_pkg::reg_addr_t rd,
  output logic              rd_write_enable,
  output rv_pkg::word_t     rd_data_in
);
  import rv_pkg::*;

  core_state_e state;
  core_state_e return_state; // where boot_send goes when done

  word_t       flash_counter;
  logic [23:0] flash_data_to_send;
  logic [4:0]  flash_bits_left;
  byte_t       flash_shift;
  byte_t       flash_bytes [4];
  logic [1:0]  flash_byte_num;
  word_t       boot_addr;    // next RAM word to fill

  word_t       pc;
  word_t       ir;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  word_t       u_imm;
  word_t       i_imm;
  word_t       s_imm;
  word_t       b_imm;
  word_t       j_imm;
  word_t       alu_b;
  word_t       sra_result;
  word_t       alu_result;
  word_t       jalr_target;
  logic        branch_taken;
  logic        illegal;

  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign rd     = ir[11:7];

  assign u_imm = {ir[31:12], 12'b0};
  assign i_imm = {{20{ir[31]}}, ir[31:20]};
  assign s_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign b_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign j_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

  assign alu_b       = (opcode == op_alu) ? rs2_data_out : i_imm; // shamt sits in i_imm[4:0]
  assign sra_result  = $signed(rs1_data_out) >>> alu_b[4:0];
  assign jalr_target = (rs1_data_out + i_imm) & ~32'd1;

  always_comb begin
    case (funct3)
      3'b000: alu_result = (opcode == op_alu && ir[30]) ? rs1_data_out - alu_b
                                                        : rs1_data_out + alu_b;
      3'b001: alu_result = rs1_data_out << alu_b[4:0];
      3'b010: alu_result = {31'b0, $signed(rs1_data_out) < $signed(alu_b)};
      3'b011: alu_result = {31'b0, rs1_data_out < alu_b};
      3'b100: alu_result = rs1_data_out ^ alu_b;
      3'b101: alu_result = ir[30] ? sra_result : rs1_data_out >> alu_b[4:0];
      3'b110: alu_result = rs1_data_out | alu_b;
      default: alu_result = rs1_data_out & alu_b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000: branch_taken = rs1_data_out == rs2_data_out;
      3'b001: branch_taken = rs1_data_out != rs2_data_out;
      3'b100: branch_taken = $signed(rs1_data_out) < $signed(rs2_data_out);
      3'b101: branch_taken = $signed(rs1_data_out) >= $signed(rs2_data_out);
      3'b110: branch_taken = rs1_data_out < rs2_data_out;
      default: branch_taken = rs1_data_out >= rs2_data_out;
    endcase
  end

  // opcode and funct3 combinations outside the supported set
  always_comb begin
    case (opcode)
      op_lui, op_auipc, op_jal, op_alu_imm, op_alu: illegal = 1'b0;
      op_jalr:   illegal = funct3 != 3'b000;
      op_branch: illegal = funct3[2:1] == 2'b01;
      op_load:   illegal = funct3 == 3'b011 || funct3[2:1] == 2'b11;
      op_store:  illegal = funct3 > 3'b010;
      default:   illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= boot_init;
      return_state    <= boot_init;
      led             <= 1'b1;
      flash_cs        <= 1'b1;
      flash_clk       <= 1'b0;
      flash_mosi      <= 1'b0;
      flash_counter   <= '0;
      flash_byte_num  <= '0;
      boot_addr       <= '0;
      pc              <= '0;
      rd_write_enable <= 1'b0;
      mem.enable      <= 1'b0;
      mem.write_type  <= wt_none;
      mem.read_type   <= rt_none;
      mem.address     <= '0;
    end else begin
      case (state)
        boot_init: begin
          flash_counter <= flash_counter + 32'd1;
          if (flash_counter >= startup_wait_cycles) begin
            flash_counter <= '0;
            state         <= boot_load_cmd;
          end
        end
        boot_load_cmd: begin
          flash_cs           <= 1'b0; // select flash
          flash_data_to_send <= {flash_read_cmd, 16'h0000};
          flash_bits_left    <= 5'd8;
          return_state       <= boot_load_addr;
          state              <= boot_send;
        end
        boot_load_addr: begin
          flash_data_to_send <= '0; // image starts at flash address 0
          flash_bits_left    <= 5'd24;
          return_state       <= boot_read_data;
          state              <= boot_send;
        end
        boot_send: begin
          if (!flash_counter[0]) begin
            flash_counter      <= 32'd1;
            flash_clk          <= 1'b0;
            flash_mosi         <= flash_data_to_send[23]; // msb first
            flash_data_to_send <= {flash_data_to_send[22:0], 1'b0};
            flash_bits_left    <= flash_bits_left - 5'd1;
          end else begin
            flash_counter <= '0;
            flash_clk     <= 1'b1; // flash samples mosi here
            if (flash_bits_left == '0) begin
              state <= return_state;
            end
          end
        end
        boot_read_data: begin
          flash_counter <= flash_counter + 32'd1;
          if (flash_counter[0]) begin
            flash_clk   <= 1'b1;
            flash_shift <= {flash_shift[6:0], flash_miso};
          end else begin
            flash_clk <= 1'b0;
            // a full byte every 16 clocks
            if (flash_counter[3:0] == 4'd0 && flash_counter != '0) begin
              flash_bytes[flash_byte_num] <= flash_shift;
              flash_byte_num              <= flash_byte_num + 2'd1;
              if (flash_byte_num == 2'd3) begin
                state <= boot_start_write;
              end
            end
          end
        end
        boot_start_write: begin
          if (!mem.busy) begin
            mem.enable     <= 1'b1;
            mem.write_type <= wt_word;
            mem.read_type  <= rt_none;
            mem.address    <= boot_addr;
            mem.data_in    <= {flash_bytes[3], flash_bytes[2], flash_bytes[1], flash_bytes[0]};
            boot_addr      <= boot_addr + 32'd4;
            state          <= boot_write;
          end
        end
        boot_write: begin
          if (!mem.busy) begin
            if (boot_addr < flash_transfer_bytes) begin
              mem.enable <= 1'b0;
              state      <= boot_read_data;
            end else begin
              flash_cs       <= 1'b1; // release flash, first fetch follows
              mem.write_type <= wt_none;
              mem.read_type  <= rt_word;
              mem.address    <= '0;
              pc             <= '0;
              state          <= cpu_fetch;
            end
          end
        end
        cpu_fetch: begin
          rd_write_enable <= 1'b0; // write-back lands in the first fetch cycle
          if (mem.data_out_ready) begin
            ir         <= mem.data_out;
            mem.enable <= 1'b0;
            state      <= cpu_execute;
          end
        end
        cpu_execute: begin
          if (illegal) begin
            led <= 1'b0; // core parks here
          end else begin
            mem.enable     <= 1'b1; // next fetch unless overridden
            mem.write_type <= wt_none;
            mem.read_type  <= rt_word;
            mem.address    <= pc + 32'd4;
            pc             <= pc + 32'd4;
            state          <= cpu_fetch;
            case (opcode)
              op_lui: begin
                rd_data_in      <= u_imm;
                rd_write_enable <= 1'b1;
              end
              op_auipc: begin
                rd_data_in      <= pc + u_imm;
                rd_write_enable <= 1'b1;
              end
              op_alu_imm, op_alu: begin
                rd_data_in      <= alu_result;
                rd_write_enable <= 1'b1;
              end
              op_jal: begin
                rd_data_in      <= pc + 32'd4;
                rd_write_enable <= 1'b1;
                mem.address     <= pc + j_imm;
                pc              <= pc + j_imm;
              end
              op_jalr: begin
                rd_data_in      <= pc + 32'd4;
                rd_write_enable <= 1'b1;
                mem.address     <= jalr_target;
                pc              <= jalr_target;
              end
              op_branch: begin
                if (branch_taken) begin
                  mem.address <= pc + b_imm;
                  pc          <= pc + b_imm;
                end
              end
              op_store: begin
                mem.write_type <= write_type_t'(funct3[1:0] + 2'd1); // sb, sh, sw
                mem.read_type  <= rt_none;
                mem.address    <= rs1_data_out + s_imm;
                mem.data_in    <= rs2_data_out;
                state          <= cpu_store;
              end
              default: begin
                // load: size from funct3[1:0], sign unless funct3[2]
                mem.read_type <= {~funct3[2], funct3[1:0] + 2'd1};
                mem.address   <= rs1_data_out + i_imm;
                state         <= cpu_load;
              end
            endcase
          end
        end
        cpu_store: begin
          if (!mem.busy) begin
            mem.write_type <= wt_none; // enable stays high into the fetch
            mem.read_type  <= rt_word;
            mem.address    <= pc;
            state          <= cpu_fetch;
          end
        end
        cpu_load: begin
          if (mem.data_out_ready) begin
            rd_data_in      <= mem.data_out;
            rd_write_enable <= 1'b1;
            mem.read_type   <= rt_word;
            mem.address     <= pc;
            state           <= cpu_fetch;
          end
        end
        default: led <= 1'b0;
      endcase
    end
  end

endmodule

// File: logic/registers.sv
/*
 * registers: rv32i register file, 32 words with x0 fixed at zero.
 * Two combinational read ports and one write port on the clock edge.
 */
module registers (
  input  logic              clk,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data_out,
  output rv_pkg::word_t     rs2_data_out,
  input  rv_pkg::reg_addr_t rd,
  input  logic              rd_write_enable,
  input  rv_pkg::word_t     rd_data_in
);
  import rv_pkg::*;

  word_t regs [32];

  assign rs1_data_out = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads zero
  assign rs2_data_out = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rd_write_enable && rd != '0) begin
      regs[rd] <= rd_data_in;
    end
  end

endmodule

// File: logic/ramio_if.sv
/*
 * ramio_if: request and response signals between the core and the memory block
 */
interface ramio_if;
  import rv_pkg::*;

  logic        enable;
  write_type_t write_type;
  read_type_t  read_type;
  word_t       address;        // byte address
  word_t       data_in;
  word_t       data_out;       // already extended per read_type
  logic        data_out_ready;
  logic        busy;

  modport core (
    output enable, write_type, read_type, address, data_in,
    input  data_out, data_out_ready, busy
  );

  modport mem (
    input  enable, write_type, read_type, address, data_in,
    output data_out, data_out_ready, busy
  );

endinterface

// File: logic/rv_pkg.sv
/*
 * rv_pkg: shared types and constants of the rv32i flash-boot system.
 * Holds the widths, memory sizes, opcodes, access codes and the core FSM states.
 */
package rv_pkg;

  typedef logic [31:0] word_t;       // data, address or instruction
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [1:0]  write_type_t; // 0 none, 1 byte, 2 half, 3 word
  typedef logic [2:0]  read_type_t;  // [1:0] size as for writes, [2] sign extend

  localparam write_type_t wt_none = 2'd0;
  localparam write_type_t wt_byte = 2'd1;
  localparam write_type_t wt_half = 2'd2;
  localparam write_type_t wt_word = 2'd3;
  localparam read_type_t  rt_none = 3'b000;
  localparam read_type_t  rt_word = 3'b111;

  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_alu_imm = 7'b0010011;
  localparam logic [6:0] op_alu     = 7'b0110011;

  localparam int startup_wait_cycles  = 20;
  localparam int flash_transfer_bytes = 256;
  localparam int ram_bytes            = 1024;
  localparam int ram_words            = ram_bytes / 4;
  localparam int ram_idx_bits         = $clog2(ram_words);

  localparam word_t io_addr        = 32'h0000_0ff0; // outside ram, decoded by ramio
  localparam byte_t flash_read_cmd = 8'h03;

  typedef enum logic [3:0] {
    boot_init,
    boot_load_cmd,
    boot_send,
    boot_load_addr,
    boot_read_data,
    boot_start_write,
    boot_write,
    cpu_fetch,
    cpu_execute,
    cpu_store,
    cpu_load
  } core_state_e;

endpackage
